// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= datapathTb
RTL_TOP   ?= datapath
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary -j 0 $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== source/aluUnit.sv ====
`include "datapath_defs.svh"

module aluUnit (
    input  logic                clk,
    input  logic                rst,
    input  logic                yIn,
    input  logic                zIn,
    input  datapathPkg::aluOp_t opcode,
    busIf.alu                   bus
);
    import datapathPkg::*;

    word_t y;
    dword_t z;
    word_t a;
    word_t b;
    logic [4:0] shamt;
    word_t low;
    dword_t product;
    dword_t result;

    assign a     = y;
    assign b     = bus.bus;
    assign shamt = b[4:0];   // counts use low 5 bits of B

    always_comb begin
        case (opcode)
            opAdd:   low = a + b;
            opSub:   low = a - b;
            opAnd:   low = a & b;
            opOr:    low = a | b;
            opShr:   low = a >> shamt;
            opShra:  low = $signed(a) >>> shamt;
            opShl:   low = a << shamt;
            opRor:   low = (a >> shamt) | (a << (`DP_WIDTH - shamt));
            opRol:   low = (a << shamt) | (a >> (`DP_WIDTH - shamt));
            opNeg:   low = -b;
            opNot:   low = ~b;
            default: low = '0;
        endcase
    end

    // operands sign-extend to the 64-bit context
    assign product = $signed(a) * $signed(b);

    assign result = (opcode == opMul) ? product : {{`DP_WIDTH{1'b0}}, low};

    always_ff @(posedge clk) begin
        if (rst) begin
            y <= '0;
            z <= '0;
        end else begin
            if (yIn) begin
                y <= bus.bus;
            end
            if (zIn) begin
                z <= result;
            end
        end
    end

    assign bus.zData = z;

    opcodeKnown: assert property (@(posedge clk) disable iff (rst)
        zIn |-> opcode inside {opAdd, opSub, opAnd, opOr, opShr, opShra, opShl,
                               opRor, opRol, opMul, opNeg, opNot});

endmodule

// ==== source/busIf.sv ====
interface busIf;
    import datapathPkg::*;

    word_t bus;       // the shared bus
    word_t regData;   // selected general/special register
    word_t mdrData;
    word_t portData;
    dword_t zData;

    modport mux (
        output bus,
        input  regData, mdrData, portData, zData
    );

    modport regs (input bus, output regData);

    modport mem (input bus, output mdrData, portData);

    modport alu (input bus, output zData);

endinterface

// ==== source/busMux.sv ====
`include "datapath_defs.svh"

module busMux (
    input  logic                    clk,
    input  datapathPkg::regMask_t   regOut,
    input  logic                    pcOut,
    input  logic                    hiOut,
    input  logic                    loOut,
    input  logic                    mdrOut,
    input  logic                    inPortOut,
    input  logic                    zHighOut,
    input  logic                    zLowOut,
    output datapathPkg::word_t      busValue,
    busIf.mux                       bus
);
    import datapathPkg::*;

    logic regSel;
    logic [`DP_REGS+6:0] outEn;
    word_t value;

    assign regSel = (|regOut) | pcOut | hiOut | loOut;   // register bank owns these
    assign outEn  = {regOut, pcOut, hiOut, loOut, mdrOut, inPortOut, zHighOut, zLowOut};

    // OR of gated sources, zero when idle
    assign value = ({`DP_WIDTH{regSel}}    & bus.regData)
                 | ({`DP_WIDTH{mdrOut}}    & bus.mdrData)
                 | ({`DP_WIDTH{inPortOut}} & bus.portData)
                 | ({`DP_WIDTH{zHighOut}}  & bus.zData[2*`DP_WIDTH-1:`DP_WIDTH])
                 | ({`DP_WIDTH{zLowOut}}   & bus.zData[`DP_WIDTH-1:0]);

    assign bus.bus  = value;
    assign busValue = value;

    // checked once the enables are driven
    singleDriver: assert property (@(posedge clk) !$isunknown(outEn) |-> $onehot0(outEn));

endmodule

// ==== source/datapath.sv ====
module datapath (
    input  logic                    clk,
    input  logic                    rst,
    input  datapathPkg::regMask_t   regIn,
    input  datapathPkg::regMask_t   regOut,
    input  logic                    pcIn,
    input  logic                    pcOut,
    input  logic                    incPc,
    input  logic                    irIn,
    input  logic                    hiIn,
    input  logic                    hiOut,
    input  logic                    loIn,
    input  logic                    loOut,
    input  logic                    mdrIn,
    input  logic                    mdrOut,
    input  logic                    read,
    input  logic                    marIn,
    input  logic                    inPortIn,
    input  logic                    inPortOut,
    input  logic                    yIn,
    input  logic                    zIn,
    input  logic                    zHighOut,
    input  logic                    zLowOut,
    input  datapathPkg::aluOp_t     opcode,
    input  datapathPkg::word_t      mdatain,
    input  datapathPkg::word_t      inPortData,
    output datapathPkg::word_t      busValue,
    output datapathPkg::word_t      marValue,
    output datapathPkg::word_t      irValue
);

    busIf dpBus ();

    memInterface uMem (
        .clk(clk), .rst(rst), .mdrIn(mdrIn), .read(read), .marIn(marIn),
        .inPortIn(inPortIn), .mdatain(mdatain), .inPortData(inPortData),
        .marValue(marValue), .bus(dpBus.mem)
    );

    registerBank uRegs (
        .clk(clk), .rst(rst), .regIn(regIn), .regOut(regOut),
        .pcIn(pcIn), .pcOut(pcOut), .incPc(incPc), .irIn(irIn),
        .hiIn(hiIn), .hiOut(hiOut), .loIn(loIn), .loOut(loOut),
        .irValue(irValue), .bus(dpBus.regs)
    );

    aluUnit uAlu (
        .clk(clk), .rst(rst), .yIn(yIn), .zIn(zIn), .opcode(opcode),
        .bus(dpBus.alu)
    );

    busMux uMux (
        .clk(clk), .regOut(regOut), .pcOut(pcOut), .hiOut(hiOut), .loOut(loOut),
        .mdrOut(mdrOut), .inPortOut(inPortOut), .zHighOut(zHighOut),
        .zLowOut(zLowOut), .busValue(busValue), .bus(dpBus.mux)
    );

endmodule

// ==== source/datapathPkg.sv ====
`include "datapath_defs.svh"

package datapathPkg;

    typedef logic [`DP_WIDTH-1:0] word_t;
    typedef logic [2*`DP_WIDTH-1:0] dword_t;   // Z register, mul product
    typedef logic [`DP_REGS-1:0] regMask_t;    // one bit per general register
    typedef logic [$clog2(`DP_REGS)-1:0] regIdx_t;

    // opcode field values, not is 01111 as in the instruction set
    typedef enum logic [`DP_OPW-1:0] {
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opShr  = 5'b00111,
        opShra = 5'b01000,
        opShl  = 5'b01001,
        opRor  = 5'b01010,
        opRol  = 5'b01011,
        opMul  = 5'b01100,
        opNeg  = 5'b01110,
        opNot  = 5'b01111
    } aluOp_t;

endpackage

// ==== source/datapath_defs.svh ====
`ifndef DATAPATH_DEFS_SVH
`define DATAPATH_DEFS_SVH

// bus and register width
`define DP_WIDTH 32

// general registers R0..R15
`define DP_REGS 16

// alu opcode width
`define DP_OPW 5

`endif

// ==== source/memInterface.sv ====
module memInterface (
    input  logic                clk,
    input  logic                rst,
    input  logic                mdrIn,
    input  logic                read,
    input  logic                marIn,
    input  logic                inPortIn,
    input  datapathPkg::word_t  mdatain,
    input  datapathPkg::word_t  inPortData,
    output datapathPkg::word_t  marValue,
    busIf.mem                   bus
);
    import datapathPkg::*;

    word_t mdr;
    word_t mar;
    word_t inPort;

    always_ff @(posedge clk) begin
        if (rst) begin
            mdr    <= '0;
            mar    <= '0;
            inPort <= '0;
        end else begin
            if (mdrIn) begin
                mdr <= read ? mdatain : bus.bus;   // memory read or bus write-back
            end
            if (marIn) begin
                mar <= bus.bus;
            end
            if (inPortIn) begin
                inPort <= inPortData;
            end
        end
    end

    assign marValue     = mar;
    assign bus.mdrData  = mdr;
    assign bus.portData = inPort;

endmodule

// ==== source/registerBank.sv ====
`include "datapath_defs.svh"

module registerBank (
    input  logic                    clk,
    input  logic                    rst,
    input  datapathPkg::regMask_t   regIn,
    input  datapathPkg::regMask_t   regOut,
    input  logic                    pcIn,
    input  logic                    pcOut,
    input  logic                    incPc,
    input  logic                    irIn,
    input  logic                    hiIn,
    input  logic                    hiOut,
    input  logic                    loIn,
    input  logic                    loOut,
    output datapathPkg::word_t      irValue,
    busIf.regs                      bus
);
    import datapathPkg::*;

    word_t gpr [`DP_REGS];
    word_t pc;
    word_t ir;
    word_t hi;
    word_t lo;
    regIdx_t outIdx;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `DP_REGS; i++) begin
                gpr[i] <= '0;
            end
            pc <= '0;
            ir <= '0;
            hi <= '0;
            lo <= '0;
        end else begin
            for (int i = 0; i < `DP_REGS; i++) begin
                if (regIn[i]) begin
                    gpr[i] <= bus.bus;
                end
            end
            if (pcIn) begin
                pc <= bus.bus;
            end else if (incPc) begin
                pc <= pc + 1'b1;
            end
            if (irIn) ir <= bus.bus;
            if (hiIn) hi <= bus.bus;
            if (loIn) lo <= bus.bus;
        end
    end

    // index of the enabled general register
    always_comb begin
        outIdx = '0;
        for (int i = 0; i < `DP_REGS; i++) begin
            if (regOut[i]) begin
                outIdx = regIdx_t'(i);
            end
        end
    end

    always_comb begin
        if (|regOut)     bus.regData = gpr[outIdx];
        else if (pcOut)  bus.regData = pc;
        else if (hiOut)  bus.regData = hi;
        else if (loOut)  bus.regData = lo;
        else             bus.regData = '0;
    end

    assign irValue = ir;

    regOutOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(regOut));

    // increment and bus load would race on PC
    pcWriteExclusive: assert property (@(posedge clk) disable iff (rst) !(incPc && pcIn));

endmodule

// ==== tb.f ====
+incdir+source
+incdir+testbench
source/datapathPkg.sv
source/busIf.sv
source/memInterface.sv
source/registerBank.sv
source/aluUnit.sv
source/busMux.sv
source/datapath.sv
testbench/datapathTb.sv

// ==== testbench/opTable.svh ====
// operand A, operand B, opcode, expected Z as {ZHigh, ZLow}
// 32-bit results sit zero-extended in ZLow
localparam int tableRows = 14;

localparam opRow_t opTable [tableRows] = '{
    '{32'h0000_0022, 32'h0000_0005, opNot,  64'h0000_0000_FFFF_FFFA},
    '{32'h0000_0012, 32'h0000_0034, opAdd,  64'h0000_0000_0000_0046},
    '{32'hFFFF_FFFF, 32'h0000_0002, opAdd,  64'h0000_0000_0000_0001},  // carry dropped
    '{32'h0000_0010, 32'h0000_0025, opSub,  64'h0000_0000_FFFF_FFEB},
    '{32'hF0F0_1234, 32'h0FF0_FF00, opAnd,  64'h0000_0000_00F0_1200},
    '{32'hF0F0_0000, 32'h0F00_00AA, opOr,   64'h0000_0000_FFF0_00AA},
    '{32'h8000_00F0, 32'h0000_0004, opShr,  64'h0000_0000_0800_000F},
    '{32'h8000_00F0, 32'h0000_0004, opShra, 64'h0000_0000_F800_000F},
    '{32'h0000_00F1, 32'h0000_0024, opShl,  64'h0000_0000_0000_0F10},  // count is 4
    '{32'h0000_0013, 32'h0000_0004, opRor,  64'h0000_0000_3000_0001},
    '{32'h8000_0001, 32'h0000_0001, opRol,  64'h0000_0000_0000_0003},
    '{32'hFFFF_FFFE, 32'h0000_0003, opMul,  64'hFFFF_FFFF_FFFF_FFFA},
    '{32'h0001_0000, 32'h0001_0000, opMul,  64'h0000_0001_0000_0000},
    '{32'h0000_0000, 32'h0000_0007, opNeg,  64'h0000_0000_FFFF_FFF9}
};

// ==== testbench/datapathTb.sv ====
`include "datapath_defs.svh"

module datapathTb;
    timeunit 1ns;
    timeprecision 100ps;
    import datapathPkg::*;

    typedef struct packed {
        word_t a;
        word_t b;
        aluOp_t op;
        dword_t res;
    } opRow_t;

    `include "opTable.svh"

    localparam int randRows = 8;
    localparam int timeoutCycles = (tableRows + randRows) * 12 + 100;
    localparam aluOp_t randOps [12] = '{opAdd, opSub, opAnd, opOr, opShr, opShra,
                                        opShl, opRor, opRol, opMul, opNeg, opNot};

    logic clk = 1'b0;
    logic rst;
    regMask_t regIn, regOut;
    logic pcIn, pcOut, incPc, irIn, hiIn, hiOut, loIn, loOut;
    logic mdrIn, mdrOut, read, marIn, inPortIn, inPortOut;
    logic yIn, zIn, zHighOut, zLowOut;
    aluOp_t opcode;
    word_t mdatain, inPortData, busValue, marValue, irValue;
    int errorCount = 0;
    word_t a, b;
    aluOp_t op;

    datapath u_datapath (.*);

    always #10 clk = ~clk;

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errorCount++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkDword(input string name, input dword_t got, input dword_t exp);
        if (got !== exp) begin
            errorCount++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic dropEnables();
        {regIn, regOut} <= '0;
        {pcIn, pcOut, incPc, irIn, hiIn, hiOut, loIn, loOut} <= '0;
        {mdrIn, mdrOut, read, marIn, inPortIn, inPortOut} <= '0;
        {yIn, zIn, zHighOut, zLowOut} <= '0;
    endtask

    // next clock edge, every enable dropped
    task automatic step();
        @(posedge clk);
        dropEnables();
    endtask

    task automatic memRead(input word_t val);
        step();
        mdatain <= val;
        read <= 1'b1;
        mdrIn <= 1'b1;
    endtask

    task automatic loadReg(input int idx, input word_t val);
        memRead(val);
        step();
        mdrOut <= 1'b1;
        regIn <= regMask_t'(1) << idx;
    endtask

    task automatic showReg(input int idx);
        step();
        regOut <= regMask_t'(1) << idx;
        @(negedge clk);
    endtask

    // Y from R1, then Z from Y op R2
    task automatic runAlu(input word_t opA, input word_t opB, input aluOp_t aluOp);
        loadReg(1, opA);
        loadReg(2, opB);
        step();
        regOut <= regMask_t'(1) << 1;
        yIn <= 1'b1;
        step();
        regOut <= regMask_t'(1) << 2;
        zIn <= 1'b1;
        opcode <= aluOp;
    endtask

    task automatic applyRow(input word_t opA, input word_t opB, input aluOp_t aluOp,
                            input dword_t expected);
        word_t lowWord;
        word_t highWord;
        runAlu(opA, opB, aluOp);
        step();
        zLowOut <= 1'b1;
        regIn <= regMask_t'(1) << 3;
        showReg(3);
        lowWord = busValue;
        step();
        zHighOut <= 1'b1;
        @(negedge clk);
        highWord = busValue;
        if (aluOp == opMul) begin
            checkDword("Z", {highWord, lowWord}, expected);
        end else begin
            checkWord("R3", lowWord, expected[31:0]);
            checkWord("ZHigh", highWord, expected[63:32]);
        end
    endtask

    // expected Z worked out from the op definitions
    function automatic dword_t refAlu(input word_t x, input word_t y, input aluOp_t f);
        int unsigned n;
        logic [63:0] twice;
        n = y[4:0];
        twice = {x, x};
        case (f)
            opAdd:   return {32'h0, x + y};
            opSub:   return {32'h0, x + ~y + 32'h1};
            opAnd:   return {32'h0, x & y};
            opOr:    return {32'h0, x | y};
            opShr:   return {32'h0, x >> n};
            opShra:  return {32'h0, (x >> n) | ({32{x[31]}} << (32 - n))};
            opShl:   return {32'h0, x << n};
            opRor:   return {32'h0, twice[n +: 32]};
            opRol:   return {32'h0, twice[63 - n -: 32]};
            opMul:   return $signed({{32{x[31]}}, x}) * $signed({{32{y[31]}}, y});
            opNeg:   return {32'h0, ~y + 32'h1};
            opNot:   return {32'h0, ~y};
            default: return '0;
        endcase
    endfunction

    initial begin
        repeat (timeoutCycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", timeoutCycles);
        $display("sim failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hb500_0666));
        rst <= 1'b1;
        opcode <= opAdd;
        mdatain <= '0;
        inPortData <= '0;
        dropEnables();
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        step();
        @(negedge clk);
        checkWord("bus idle", busValue, '0);
        showReg(5);
        checkWord("R5", busValue, '0);
        step();
        pcOut <= 1'b1;
        @(negedge clk);
        checkWord("PC", busValue, '0);
        step();
        zLowOut <= 1'b1;
        @(negedge clk);
        checkWord("ZLow", busValue, '0);

        // fill every register first, so a shared or aliased entry shows up
        for (int i = 0; i < `DP_REGS; i++) begin
            loadReg(i, 32'hA5A5_0000 | (i * 32'h0101));
        end
        for (int i = 0; i < `DP_REGS; i++) begin
            showReg(i);
            checkWord($sformatf("R%0d", i), busValue, 32'hA5A5_0000 | (i * 32'h0101));
        end

        for (int i = 0; i < tableRows; i++) begin
            applyRow(opTable[i].a, opTable[i].b, opTable[i].op, opTable[i].res);
        end
        for (int i = 0; i < randRows; i++) begin
            a = $urandom;
            b = $urandom;
            op = randOps[$urandom % 12];
            applyRow(a, b, op, refAlu(a, b, op));
        end

        // fetch: PC to MAR, then increment
        memRead(32'h0000_0040);
        step();
        mdrOut <= 1'b1;
        pcIn <= 1'b1;
        step();
        pcOut <= 1'b1;
        marIn <= 1'b1;
        incPc <= 1'b1;
        step();
        pcOut <= 1'b1;
        @(negedge clk);
        checkWord("MAR", marValue, 32'h0000_0040);
        checkWord("PC", busValue, 32'h0000_0041);
        memRead(32'h1234_ABCD);
        step();
        mdrOut <= 1'b1;
        irIn <= 1'b1;
        step();
        @(negedge clk);
        checkWord("IR", irValue, 32'h1234_ABCD);

        runAlu(32'h0000_0101, 32'h8000_0000, opMul);   // product FFFFFF7F_80000000
        step();
        zHighOut <= 1'b1;
        hiIn <= 1'b1;
        step();
        zLowOut <= 1'b1;
        loIn <= 1'b1;
        step();
        hiOut <= 1'b1;
        @(negedge clk);
        checkWord("HI", busValue, 32'hFFFF_FF7F);
        step();
        loOut <= 1'b1;
        @(negedge clk);
        checkWord("LO", busValue, 32'h8000_0000);

        step();
        inPortData <= 32'hC0DE_0042;
        inPortIn <= 1'b1;
        step();
        inPortOut <= 1'b1;
        @(negedge clk);
        checkWord("inPort", busValue, 32'hC0DE_0042);
        step();

        $display("errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
